// ==== logic/iq_cfg.svh ====
// sizes are fixed for two threads of 16 entries; IQ_PTR_W must equal log2 of IQ_DEPTH.
`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// storage geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// threads sharing the array.
`define IQ_THREADS 2
// entries per thread region.
`define IQ_DEPTH 16
`define IQ_PTR_W 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port widths and stall level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define IQ_WR_LANES 4
`define IQ_RD_LANES 2
// fill count that raises the full stall, leaves room for one full write group.
`define IQ_FULL_LEVEL 13

`endif

// ==== logic/iq_ctl_pkg.sv ====
// control types for the extra-data queue; widths follow the macros in the config header.
`default_nettype none

`include "iq_cfg.svh"

package iq_ctl_pkg;

  // thread id.
  typedef logic [$clog2(`IQ_THREADS)-1:0] thread_t;

  // position inside one thread region.
  typedef logic [`IQ_PTR_W-1:0] ptr_t;

  // storage address, thread id above the pointer.
  typedef logic [$bits(thread_t)+`IQ_PTR_W-1:0] addr_t;

  // fill count, 0 to IQ_DEPTH.
  typedef logic [$clog2(`IQ_DEPTH+1)-1:0] fill_t;

  // records written and read per cycle.
  typedef logic [$clog2(`IQ_WR_LANES+1)-1:0] wr_cnt_t;
  typedef logic [$clog2(`IQ_RD_LANES+1)-1:0] rd_cnt_t;

  // first valid slot of the input group.
  typedef logic [$clog2(`IQ_WR_LANES)-1:0] slot_t;

endpackage

`default_nettype wire

// ==== logic/iq_extra_queue.sv ====
// read outputs are undefined after a flush until the next load; no underflow protection.
`timescale 1ns/1ps
`default_nettype none

module iq_extra_queue
  import iq_ctl_pkg::*, iq_payload_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      flush,
  input  thread_t   flush_thread,
  input  logic      fetch_stall,
  output logic      full_stall,
  input  logic      write_en,
  input  thread_t   write_thread,
  input  wr_cnt_t   write_cnt,
  input  slot_t     write_start,
  input  iq_extra_t write_data0,
  input  iq_extra_t write_data1,
  input  iq_extra_t write_data2,
  input  iq_extra_t write_data3,
  input  logic      issue_stall,
  input  thread_t   read_thread,
  input  rd_cnt_t   read_cnt,
  output iq_extra_t read_data0,
  output iq_extra_t read_data1
);

  logic  write_accept;
  ptr_t  tail;
  addr_t rd_addr0;
  addr_t rd_addr1;
  logic  rd_load;

  iq_wr_if #(.payload_t(iq_extra_t)) wr_bus ();

  // head, tail and fill tracking.
  iq_ptr_ctl u_ctl (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .flush_thread (flush_thread),
    .fetch_stall  (fetch_stall),
    .write_en     (write_en),
    .write_thread (write_thread),
    .write_cnt    (write_cnt),
    .issue_stall  (issue_stall),
    .read_thread  (read_thread),
    .read_cnt     (read_cnt),
    .full_stall   (full_stall),
    .write_accept (write_accept),
    .tail         (tail),
    .rd_addr0     (rd_addr0),
    .rd_addr1     (rd_addr1),
    .rd_load      (rd_load)
  );

  // slot alignment onto the write lanes.
  iq_write_pack u_pack (
    .write_accept (write_accept),
    .write_thread (write_thread),
    .tail         (tail),
    .write_cnt    (write_cnt),
    .write_start  (write_start),
    .write_data0  (write_data0),
    .write_data1  (write_data1),
    .write_data2  (write_data2),
    .write_data3  (write_data3),
    .wr           (wr_bus.src)
  );

  iq_extra_ram #(.payload_t(iq_extra_t)) u_ram (
    .clk      (clk),
    .rst      (rst),
    .wr       (wr_bus.mem),
    .rd_load  (rd_load),
    .rd_addr0 (rd_addr0),
    .rd_addr1 (rd_addr1),
    .rd_data0 (read_data0),
    .rd_data1 (read_data1)
  );

endmodule

`default_nettype wire

// ==== logic/iq_extra_ram.sv ====
// array contents are not reset; reads are asynchronous from registered addresses, so writes show first.
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module iq_extra_ram
  import iq_ctl_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  iq_wr_if.mem     wr,
  input  logic     rd_load,
  input  addr_t    rd_addr0,
  input  addr_t    rd_addr1,
  output payload_t rd_data0,
  output payload_t rd_data1
);

  localparam int ENTRIES = `IQ_THREADS * `IQ_DEPTH;

  payload_t mem [ENTRIES];

  addr_t rd_addr0_q;
  addr_t rd_addr1_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write ports.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // lane addresses never collide.
  always_ff @(posedge clk) begin
    for (int i = 0; i < `IQ_WR_LANES; i++) begin
      if (wr.en[i]) begin
        mem[wr.addr[i]] <= wr.data[i];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read ports.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr0_q <= '0;
      rd_addr1_q <= '0;
    end else if (rd_load) begin
      rd_addr0_q <= rd_addr0;
      rd_addr1_q <= rd_addr1;
    end
  end

  assign rd_data0 = mem[rd_addr0_q];
  assign rd_data1 = mem[rd_addr1_q];

endmodule

`default_nettype wire

// ==== logic/iq_payload_pkg.sv ====
// extra-data record stored per fetched instruction; 45 bits packed, field order is fixed.
`default_nettype none

package iq_payload_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // side data carried beside the main instruction queue.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    // predicted branch target.
    logic [31:0] target;
    // predictor says taken.
    logic        taken;
    // predictor saw a branch here.
    logic        pred_branch;
    // offset of the instruction inside the fetch block.
    logic [9:0]  pc_off;
    // last instruction of its fetch bundle.
    logic        last;
  } iq_extra_t;

endpackage

`default_nettype wire

// ==== logic/iq_ptr_ctl.sv ====
// no underflow guard; the reader must not take more than the thread holds. flush blocks writes.
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module iq_ptr_ctl
  import iq_ctl_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  thread_t flush_thread,
  input  logic    fetch_stall,
  input  logic    write_en,
  input  thread_t write_thread,
  input  wr_cnt_t write_cnt,
  input  logic    issue_stall,
  input  thread_t read_thread,
  input  rd_cnt_t read_cnt,
  output logic    full_stall,
  output logic    write_accept,
  output ptr_t    tail,
  output addr_t   rd_addr0,
  output addr_t   rd_addr1,
  output logic    rd_load
);

  // per-thread state.
  ptr_t  head_q   [`IQ_THREADS];
  ptr_t  tail_q   [`IQ_THREADS];
  fill_t cnt_q    [`IQ_THREADS];

  ptr_t  head_nxt [`IQ_THREADS];
  ptr_t  tail_nxt [`IQ_THREADS];
  fill_t cnt_nxt  [`IQ_THREADS];

  logic  rd_step;
  ptr_t  rd_head;
  ptr_t  rd_head1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // stall is on the writer's own fill level.
  assign full_stall   = (cnt_q[write_thread] >= fill_t'(`IQ_FULL_LEVEL));
  assign write_accept = write_en && !fetch_stall && !full_stall && !flush;

  // a flush cycle freezes both heads.
  assign rd_step = !issue_stall && !flush;
  assign rd_load = !issue_stall;

  assign tail = tail_q[write_thread];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointer and count update per thread.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar t = 0; t < `IQ_THREADS; t++) begin : g_thr
    logic    wr_hit;
    logic    rd_hit;
    wr_cnt_t wr_add;
    rd_cnt_t rd_add;

    assign wr_hit = write_accept && (write_thread == thread_t'(t));
    assign rd_hit = rd_step && (read_thread == thread_t'(t));
    assign wr_add = wr_hit ? write_cnt : '0;
    assign rd_add = rd_hit ? read_cnt : '0;

    // pointers wrap inside the 16-entry region.
    assign head_nxt[t] = head_q[t] + ptr_t'(rd_add);
    assign tail_nxt[t] = tail_q[t] + ptr_t'(wr_add);
    // write and read may land on the same thread in one cycle.
    assign cnt_nxt[t]  = cnt_q[t] + fill_t'(wr_add) - fill_t'(rd_add);

    always_ff @(posedge clk) begin
      if (rst) begin
        head_q[t] <= '0;
        tail_q[t] <= '0;
        cnt_q[t]  <= '0;
      end else if (flush && (flush_thread == thread_t'(t))) begin
        head_q[t] <= '0;
        tail_q[t] <= '0;
        cnt_q[t]  <= '0;
      end else begin
        head_q[t] <= head_nxt[t];
        tail_q[t] <= tail_nxt[t];
        cnt_q[t]  <= cnt_nxt[t];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read addresses.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // next head of the read thread and the entry behind it.
  assign rd_head  = head_nxt[read_thread];
  assign rd_head1 = rd_head + ptr_t'(1);

  assign rd_addr0 = {read_thread, rd_head};
  assign rd_addr1 = {read_thread, rd_head1};

endmodule

`default_nettype wire

// ==== logic/iq_wr_if.sv ====
// four-lane storage write bus; enabled lanes must carry distinct addresses.
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

interface iq_wr_if
  import iq_ctl_pkg::*;
#(
  parameter type payload_t = logic
) ();

  // one address, data word and enable per lane.
  addr_t    addr [`IQ_WR_LANES];
  payload_t data [`IQ_WR_LANES];
  logic     en   [`IQ_WR_LANES];

  // lane packer side.
  modport src (
    output addr,
    output data,
    output en
  );

  // storage side, all enabled lanes write on the same edge.
  modport mem (
    input addr,
    input data,
    input en
  );

endinterface

`default_nettype wire

// ==== logic/iq_write_pack.sv ====
// writer keeps write_start+write_cnt at 4 or less; lanes past slot 3 repeat slot 3, disabled.
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module iq_write_pack
  import iq_ctl_pkg::*, iq_payload_pkg::*;
(
  input  logic      write_accept,
  input  thread_t   write_thread,
  input  ptr_t      tail,
  input  wr_cnt_t   write_cnt,
  input  slot_t     write_start,
  input  iq_extra_t write_data0,
  input  iq_extra_t write_data1,
  input  iq_extra_t write_data2,
  input  iq_extra_t write_data3,
  iq_wr_if.src      wr
);

  localparam int SUM_W = $bits(slot_t) + 1;

  iq_extra_t slot_data [`IQ_WR_LANES];

  assign slot_data[0] = write_data0;
  assign slot_data[1] = write_data1;
  assign slot_data[2] = write_data2;
  assign slot_data[3] = write_data3;

  for (genvar i = 0; i < `IQ_WR_LANES; i++) begin : g_lane
    logic [SUM_W-1:0] slot_sum;
    slot_t            slot_sel;

    // lane i takes slot start+i, clamped to the last slot.
    assign slot_sum = {1'b0, write_start} + SUM_W'(i);
    assign slot_sel = (slot_sum >= SUM_W'(`IQ_WR_LANES)) ?
                      slot_t'(`IQ_WR_LANES - 1) : slot_t'(slot_sum);

    assign wr.data[i] = slot_data[slot_sel];
    // tail+i wraps inside the thread region.
    assign wr.addr[i] = {write_thread, tail + ptr_t'(i)};
    assign wr.en[i]   = write_accept && (wr_cnt_t'(i) < write_cnt);
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/iq_ctl_pkg.sv
logic/iq_payload_pkg.sv
logic/iq_wr_if.sv
logic/iq_ptr_ctl.sv
logic/iq_write_pack.sv
logic/iq_extra_ram.sv
logic/iq_extra_queue.sv
tb/iq_extra_queue_sva.sv
tb/iq_extra_queue_tb.sv

// ==== tb/iq_extra_queue_sva.sv ====
// shadow fill count is rebuilt from the top-level ports; assumes reads never pass the fill level.
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module iq_extra_queue_sva
  import iq_ctl_pkg::*, iq_payload_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      flush,
  input thread_t   flush_thread,
  input logic      fetch_stall,
  input logic      full_stall,
  input logic      write_en,
  input thread_t   write_thread,
  input wr_cnt_t   write_cnt,
  input logic      issue_stall,
  input thread_t   read_thread,
  input rd_cnt_t   read_cnt,
  input iq_extra_t read_data0,
  input iq_extra_t read_data1
);

  fill_t shadow [`IQ_THREADS];
  logic  write_ok;
  logic  read_ok;
  int    assert_fails = 0;

  assign write_ok = write_en && !fetch_stall && !full_stall && !flush;
  assign read_ok  = !issue_stall && !flush;

  // per-thread fill count seen from outside.
  always_ff @(posedge clk) begin
    for (int t = 0; t < `IQ_THREADS; t++) begin
      if (rst || (flush && (flush_thread == thread_t'(t)))) begin
        shadow[t] <= '0;
      end else begin
        shadow[t] <= shadow[t]
                     + ((write_ok && (write_thread == thread_t'(t))) ? fill_t'(write_cnt) : '0)
                     - ((read_ok && (read_thread == thread_t'(t))) ? fill_t'(read_cnt) : '0);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // port properties.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  no_underflow: assert property (@(posedge clk) disable iff (rst)
    read_ok |-> (fill_t'(read_cnt) <= shadow[read_thread]))
    else begin
      assert_fails++;
      $error("read_cnt is larger than the entries held by the read thread");
    end

  full_low_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !full_stall)
    else begin
      assert_fails++;
      $error("full_stall is high in the first cycle after reset");
    end

  // outputs hold while issue is stalled.
  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    issue_stall |=> ($stable(read_data0) && $stable(read_data1)))
    else begin
      assert_fails++;
      $error("read outputs changed while issue_stall was high");
    end

endmodule

bind iq_extra_queue iq_extra_queue_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .flush        (flush),
  .flush_thread (flush_thread),
  .fetch_stall  (fetch_stall),
  .full_stall   (full_stall),
  .write_en     (write_en),
  .write_thread (write_thread),
  .write_cnt    (write_cnt),
  .issue_stall  (issue_stall),
  .read_thread  (read_thread),
  .read_cnt     (read_cnt),
  .read_data0   (read_data0),
  .read_data1   (read_data1)
);

`default_nettype wire

// ==== tb/iq_extra_queue_tb.sv ====
// table rows keep write_start+write_cnt at 4 or less and never read more than a thread holds.
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module iq_extra_queue_tb
  import iq_ctl_pkg::*, iq_payload_pkg::*;
();

  typedef enum int {OP_WRITE, OP_FWRITE, OP_READ, OP_SREAD, OP_FLUSH, OP_IDLE} op_e;

  typedef struct {
    op_e op;
    int  thr;
    int  cnt;
    int  start;
    int  seed;
  } row_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      flush;
  thread_t   flush_thread;
  logic      fetch_stall;
  logic      full_stall;
  logic      write_en;
  thread_t   write_thread;
  wr_cnt_t   write_cnt;
  slot_t     write_start;
  iq_extra_t write_data0;
  iq_extra_t write_data1;
  iq_extra_t write_data2;
  iq_extra_t write_data3;
  logic      issue_stall;
  thread_t   read_thread;
  rd_cnt_t   read_cnt;
  iq_extra_t read_data0;
  iq_extra_t read_data1;

  row_t        rows [$];
  iq_extra_t   model_q [`IQ_THREADS][$];
  iq_extra_t   slot_rec [`IQ_WR_LANES];
  iq_extra_t   exp0;
  iq_extra_t   exp1;
  logic        exp0_ok = 1'b0;
  logic        exp1_ok = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  iq_extra_queue u_dut (.*);

  always #50 clk = ~clk;

  // run limit from the table length.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
      $display("timeout after %0d cycles, the operation table did not finish", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic add_row(op_e op, int thr, int cnt, int start, int seed);
    row_t r;
    r.op    = op;
    r.thr   = thr;
    r.cnt   = cnt;
    r.start = start;
    r.seed  = seed;
    rows.push_back(r);
  endtask

  function automatic iq_extra_t make_record(int seed, int slot);
    iq_extra_t r;
    r.target      = $urandom;
    r.taken       = $urandom_range(1, 0);
    r.pred_branch = $urandom_range(1, 0);
    r.pc_off      = 10'(seed * 4 + slot);
    r.last        = (slot == `IQ_WR_LANES - 1);
    return r;
  endfunction

  task automatic check_val(string name, logic [63:0] expv, logic [63:0] act);
    checks++;
    assert (act === expv) else begin
      errors++;
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, expv, act);
    end
  endtask

  task automatic drive_idle();
    flush        = 1'b0;
    flush_thread = '0;
    fetch_stall  = 1'b0;
    write_en     = 1'b0;
    write_thread = '0;
    write_cnt    = '0;
    write_start  = '0;
    write_data0  = '0;
    write_data1  = '0;
    write_data2  = '0;
    write_data3  = '0;
    issue_stall  = 1'b0;
    read_thread  = '0;
    read_cnt     = '0;
  endtask

  // expected outputs after a read load, head and head+1 of the thread.
  task automatic set_expect(int thr);
    exp0_ok = (model_q[thr].size() > 0);
    exp1_ok = (model_q[thr].size() > 1);
    if (exp0_ok) exp0 = model_q[thr][0];
    if (exp1_ok) exp1 = model_q[thr][1];
  endtask

  task automatic check_outputs();
    if (exp0_ok) check_val("read_data0", exp0, read_data0);
    if (exp1_ok) check_val("read_data1", exp1, read_data1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one table row per cycle.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic apply_row(row_t r);
    logic full_exp;
    logic acc_exp;
    @(negedge clk);
    check_outputs();
    drive_idle();
    write_thread = thread_t'(r.thr);
    read_thread  = thread_t'(r.thr);
    flush_thread = thread_t'(r.thr);
    case (r.op)
      OP_WRITE, OP_FWRITE: begin
        for (int s = 0; s < `IQ_WR_LANES; s++) begin
          slot_rec[s] = make_record(r.seed, s);
        end
        write_data0 = slot_rec[0];
        write_data1 = slot_rec[1];
        write_data2 = slot_rec[2];
        write_data3 = slot_rec[3];
        write_en    = 1'b1;
        fetch_stall = (r.op == OP_FWRITE);
        write_cnt   = wr_cnt_t'(r.cnt);
        write_start = slot_t'(r.start);
      end
      OP_READ: read_cnt = rd_cnt_t'(r.cnt);
      OP_SREAD: begin
        issue_stall = 1'b1;
        read_cnt    = rd_cnt_t'(r.cnt);
      end
      OP_FLUSH: flush = 1'b1;
      default: ;
    endcase
    full_exp = (model_q[r.thr].size() >= `IQ_FULL_LEVEL);
    acc_exp  = (r.op == OP_WRITE) && !full_exp;
    #1;
    check_val("full_stall", full_exp, full_stall);
    check_val("write_accept", acc_exp, u_dut.write_accept);
    if (acc_exp) begin
      for (int s = r.start; s < r.start + r.cnt; s++) begin
        model_q[r.thr].push_back(slot_rec[s]);
      end
    end
    if (r.op == OP_READ) begin
      repeat (r.cnt) void'(model_q[r.thr].pop_front());
    end
    // flushed outputs stay unknown until the next load.
    if (r.op == OP_FLUSH) begin
      model_q[r.thr].delete();
      exp0_ok = 1'b0;
      exp1_ok = 1'b0;
    end else if (r.op != OP_SREAD) begin
      set_expect(r.thr);
    end
  endtask

  task automatic build_table();
    add_row(OP_WRITE, 0, 1, 0, 1);
    add_row(OP_WRITE, 0, 2, 1, 2);
    add_row(OP_WRITE, 0, 3, 0, 3);
    add_row(OP_WRITE, 0, 4, 0, 4);
    add_row(OP_READ,  0, 1, 0, 0);
    add_row(OP_READ,  0, 2, 0, 0);
    add_row(OP_READ,  0, 0, 0, 0);
    add_row(OP_WRITE, 0, 2, 2, 5);
    add_row(OP_WRITE, 0, 1, 3, 6);
    // write offered under fetch stall is dropped.
    add_row(OP_FWRITE, 0, 2, 0, 18);
    // interleaved threads.
    add_row(OP_WRITE, 1, 3, 1, 7);
    add_row(OP_READ,  0, 2, 0, 0);
    add_row(OP_WRITE, 1, 2, 0, 8);
    add_row(OP_READ,  1, 2, 0, 0);
    // fill thread 0 past the stall level.
    add_row(OP_WRITE, 0, 4, 0, 9);
    add_row(OP_WRITE, 0, 2, 2, 10);
    add_row(OP_WRITE, 0, 4, 0, 11);
    add_row(OP_READ,  0, 2, 0, 0);
    add_row(OP_WRITE, 0, 1, 1, 12);
    add_row(OP_WRITE, 0, 3, 1, 13);
    add_row(OP_SREAD, 0, 2, 0, 0);
    add_row(OP_SREAD, 0, 1, 0, 0);
    add_row(OP_READ,  0, 2, 0, 0);
    add_row(OP_WRITE, 0, 1, 0, 14);
    // flush thread 0, thread 1 carries on.
    add_row(OP_FLUSH, 0, 0, 0, 0);
    add_row(OP_IDLE,  1, 0, 0, 0);
    add_row(OP_WRITE, 0, 2, 1, 15);
    add_row(OP_READ,  1, 1, 0, 0);
    add_row(OP_READ,  0, 1, 0, 0);
    add_row(OP_WRITE, 1, 4, 0, 16);
    add_row(OP_READ,  1, 2, 0, 0);
    add_row(OP_READ,  0, 1, 0, 0);
    add_row(OP_WRITE, 0, 3, 1, 17);
    add_row(OP_READ,  0, 2, 0, 0);
    add_row(OP_IDLE,  0, 0, 0, 0);
  endtask

  initial begin
    void'($urandom(4269));
    drive_idle();
    rst = 1'b1;
    build_table();
    cycle_limit = rows.size() * 4 + 20;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    @(negedge clk);
    check_outputs();
    errors = errors + u_dut.u_sva.assert_fails;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
